// ==== Makefile ====
# Verilator build and run of the execute stage testbench

LOG := sim.log

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module tb_ex_stage -f compile.f -Mdir obj_dir -o sim_ex_stage
	./obj_dir/sim_ex_stage | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean

// ==== compile.f ====
design/ex_pkg.sv
design/ex_decode.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_mem_req.sv
design/ex_stage.sv
tests/ex_checker.sv
tests/tb_ex_stage.sv

// ==== design/ex_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_alu
    import ex_pkg::*;
(
    input  wire exec_ctrl_t ctrl_i,
    input  wire xword_t     op1_i,
    input  wire xword_t     op2_i,
    input  wire xword_t     base_addr_i,
    input  wire xword_t     offset_addr_i,
    output xword_t          result_o,
    output xword_t          addr_o,
    output cmp_flags_t      cmp_o
);

    logic [5:0]      shamt;     // 64-bit shifts
    logic [4:0]      shamt_w;   // word shifts
    logic [WLEN-1:0] op1_w;
    xword_t          res_d;
    logic [WLEN-1:0] res_w;

    assign shamt   = op2_i[5:0];
    assign shamt_w = op2_i[4:0];
    assign op1_w   = op1_i[WLEN-1:0];

    // flags feed both SLT and the branch unit
    assign cmp_o.eq  = (op1_i == op2_i);
    assign cmp_o.lt  = ($signed(op1_i) < $signed(op2_i));
    assign cmp_o.ltu = (op1_i < op2_i);

    assign addr_o = base_addr_i + offset_addr_i;   // branch/jump target, load/store address

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:    res_d = op1_i + op2_i;
            ALU_SUB:    res_d = op1_i - op2_i;
            ALU_SLL:    res_d = op1_i << shamt;
            ALU_SLT:    res_d = {{(XLEN-1){1'b0}}, cmp_o.lt};
            ALU_SLTU:   res_d = {{(XLEN-1){1'b0}}, cmp_o.ltu};
            ALU_XOR:    res_d = op1_i ^ op2_i;
            ALU_SRL:    res_d = op1_i >> shamt;
            ALU_SRA:    res_d = $signed(op1_i) >>> shamt;
            ALU_OR:     res_d = op1_i | op2_i;
            ALU_AND:    res_d = op1_i & op2_i;
            ALU_PASS_B: res_d = op2_i;
            default:    res_d = '0;
        endcase
    end

    // word forms; add/sub low half is the same as the 64-bit sum
    always_comb begin
        case (ctrl_i.alu_op)
            ALU_SLL: res_w = op1_w << shamt_w;
            ALU_SRL: res_w = op1_w >> shamt_w;
            ALU_SRA: res_w = $signed(op1_w) >>> shamt_w;   // fill from bit 31
            default: res_w = res_d[WLEN-1:0];
        endcase
    end

    assign result_o = ctrl_i.word_op ? {{(XLEN-WLEN){res_w[WLEN-1]}}, res_w} : res_d;

endmodule

`default_nettype wire

// ==== design/ex_branch.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_branch
    import ex_pkg::*;
(
    input  wire exec_ctrl_t ctrl_i,
    input  wire cmp_flags_t cmp_i,
    input  wire xword_t     addr_i,
    output jump_req_t       jump_o
);

    logic taken;

    always_comb begin
        taken = 1'b0;
        case (ctrl_i.unit)
            UNIT_BRANCH: begin
                case (ctrl_i.br_cond)
                    BR_EQ:   taken = cmp_i.eq;
                    BR_NE:   taken = ~cmp_i.eq;
                    BR_LT:   taken = cmp_i.lt;
                    BR_GE:   taken = ~cmp_i.lt;
                    BR_LTU:  taken = cmp_i.ltu;
                    BR_GEU:  taken = ~cmp_i.ltu;
                    default: taken = 1'b0;
                endcase
            end
            UNIT_JUMP: taken = 1'b1;   // JAL and JALR always redirect
            default:   taken = 1'b0;
        endcase
    end

    // not taken leaves the whole request at zero
    assign jump_o.en   = taken;
    assign jump_o.addr = taken ? addr_i : '0;

endmodule

`default_nettype wire

// ==== design/ex_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_decode
    import ex_pkg::*;
(
    input  wire inst_t     inst_i,
    input  wire reg_addr_t rd_addr_i,
    output exec_ctrl_t     ctrl_o
);

    opcode_e    opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    logic [5:0] func6;
    logic       reg_f7_ok;    // func7 legal for a register-form func3
    logic       word_f3_ok;   // func3 exists in the *W tables
    logic       imm_sh_ok;    // shift func6 legal for OP-IMM

    assign opcode = opcode_e'(inst_i[6:0]);
    assign func3  = inst_i[14:12];
    assign func7  = inst_i[31:25];
    assign func6  = inst_i[31:26];

    // M extension has func7 = 0000001 and falls out here
    assign reg_f7_ok = (func7 == F7_BASE) ||
                       ((func7 == F7_ALT) && ((func3 == F3_ADD_SUB) || (func3 == F3_SRL_SRA)));

    assign word_f3_ok = (func3 == F3_ADD_SUB) || (func3 == F3_SLL) || (func3 == F3_SRL_SRA);

    assign imm_sh_ok = (func6 == F6_SHIFT_LOGIC) ||
                       ((func6 == F6_SHIFT_ARITH) && (func3 == F3_SRL_SRA));

    always_comb begin
        ctrl_o = '0;   // class NONE, ADD, no write
        case (opcode)
            OPC_OP: begin
                if (reg_f7_ok) begin
                    ctrl_o.unit   = UNIT_ALU;
                    ctrl_o.alu_op = alu_op_e'({func7[5], func3});
                end
            end
            OPC_OP_32: begin
                if (reg_f7_ok && word_f3_ok) begin
                    ctrl_o.unit    = UNIT_ALU;
                    ctrl_o.alu_op  = alu_op_e'({func7[5], func3});
                    ctrl_o.word_op = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (((func3 != F3_SLL) && (func3 != F3_SRL_SRA)) || imm_sh_ok) begin
                    ctrl_o.unit   = UNIT_ALU;
                    // imm bit 30 only means SRAI, never SUB
                    ctrl_o.alu_op = alu_op_e'({(func3 == F3_SRL_SRA) & func7[5], func3});
                end
            end
            OPC_OP_IMM_32: begin
                if (func3 == F3_ADD_SUB) begin   // ADDIW, any immediate
                    ctrl_o.unit    = UNIT_ALU;
                    ctrl_o.word_op = 1'b1;
                end else if (reg_f7_ok && word_f3_ok) begin
                    ctrl_o.unit    = UNIT_ALU;
                    ctrl_o.alu_op  = alu_op_e'({func7[5], func3});
                    ctrl_o.word_op = 1'b1;
                end
            end
            OPC_LUI: begin
                ctrl_o.unit   = UNIT_ALU;
                ctrl_o.alu_op = ALU_PASS_B;   // op2 carries the shifted imm
            end
            OPC_AUIPC: ctrl_o.unit = UNIT_ALU;   // pc + imm
            OPC_JAL:   ctrl_o.unit = UNIT_JUMP;  // link = op1 + op2
            OPC_JALR: begin
                if (func3 == F3_JALR) ctrl_o.unit = UNIT_JUMP;
            end
            OPC_BRANCH: begin
                if (func3[2:1] != 2'b01) begin   // 010 and 011 are reserved
                    ctrl_o.unit    = UNIT_BRANCH;
                    ctrl_o.br_cond = br_cond_e'(func3);
                end
            end
            OPC_LOAD: begin
                if (func3 != F3_LOAD_RSVD) begin
                    ctrl_o.unit     = UNIT_LOAD;
                    ctrl_o.mem_size = mem_size_e'(func3[1:0]);
                end
            end
            OPC_STORE: begin
                if (!func3[2]) begin
                    ctrl_o.unit     = UNIT_STORE;
                    ctrl_o.mem_size = mem_size_e'(func3[1:0]);
                end
            end
            default: ctrl_o = '0;   // CSR, fence, unknown
        endcase

        // only classes with a register result carry rd
        if (ctrl_o.unit inside {UNIT_ALU, UNIT_JUMP, UNIT_LOAD}) ctrl_o.rd = rd_addr_i;
    end

endmodule

`default_nettype wire

// ==== design/ex_mem_req.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_mem_req
    import ex_pkg::*;
(
    input  wire exec_ctrl_t ctrl_i,
    input  wire xword_t     op2_i,
    input  wire xword_t     result_i,
    input  wire xword_t     addr_i,
    output wb_req_t         wb_o,
    output mem_req_t        mem_o
);

    xword_t     st_data;
    logic [7:0] st_mask;

    // store data is zero-extended from the access size
    always_comb begin
        case (ctrl_i.mem_size)
            MEM_BYTE: begin
                st_data = {{(XLEN-8){1'b0}}, op2_i[7:0]};
                st_mask = 8'b0000_0001;
            end
            MEM_HALF: begin
                st_data = {{(XLEN-16){1'b0}}, op2_i[15:0]};
                st_mask = 8'b0000_0011;
            end
            MEM_WORD: begin
                st_data = {{(XLEN-32){1'b0}}, op2_i[31:0]};
                st_mask = 8'b0000_1111;
            end
            default: begin   // double
                st_data = op2_i;
                st_mask = 8'b1111_1111;
            end
        endcase
    end

    always_comb begin
        wb_o  = '0;
        mem_o = '0;
        case (ctrl_i.unit)
            UNIT_ALU, UNIT_JUMP: begin
                wb_o.wen  = 1'b1;
                wb_o.addr = ctrl_i.rd;
                wb_o.data = result_i;   // jumps write the link value
            end
            UNIT_LOAD: begin
                wb_o.wen    = 1'b1;     // data arrives in a later stage
                wb_o.addr   = ctrl_i.rd;
                mem_o.ren   = 1'b1;
                mem_o.raddr = addr_i;
            end
            UNIT_STORE: begin
                mem_o.wen   = 1'b1;
                mem_o.waddr = addr_i;
                mem_o.wdata = st_data;
                mem_o.wmask = st_mask;
            end
            default: begin
                wb_o  = '0;   // branches and unknown encodings
                mem_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int XLEN = 64;
    localparam int WLEN = 32;   // width of the *W operations

    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [XLEN-1:0] xword_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b0000011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_AUIPC     = 7'b0010111,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_STORE     = 7'b0100011,
        OPC_OP        = 7'b0110011,
        OPC_LUI       = 7'b0110111,
        OPC_OP_32     = 7'b0111011,
        OPC_BRANCH    = 7'b1100011,
        OPC_JALR      = 7'b1100111,
        OPC_JAL       = 7'b1101111
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB   = 3'b000;
    localparam logic [2:0] F3_SLL       = 3'b001;
    localparam logic [2:0] F3_SRL_SRA   = 3'b101;
    localparam logic [2:0] F3_JALR      = 3'b000;
    localparam logic [2:0] F3_LOAD_RSVD = 3'b111;   // no LDU in RV64I

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // selects SUB / SRA

    // 64-bit immediate shifts: inst[25] is shamt[5], so only inst[31:26] is func
    localparam logic [5:0] F6_SHIFT_LOGIC = 6'b000000;
    localparam logic [5:0] F6_SHIFT_ARITH = 6'b010000;

    // encoded as {alt bit, func3} so the decoder can build it directly
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_SRA    = 4'b1101,
        ALU_PASS_B = 4'b1111
    } alu_op_e;

    typedef enum logic [2:0] {
        UNIT_NONE   = 3'd0,
        UNIT_ALU    = 3'd1,
        UNIT_BRANCH = 3'd2,
        UNIT_JUMP   = 3'd3,
        UNIT_LOAD   = 3'd4,
        UNIT_STORE  = 3'd5
    } unit_e;

    // same codes as the branch func3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    // func3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE   = 2'b00,
        MEM_HALF   = 2'b01,
        MEM_WORD   = 2'b10,
        MEM_DOUBLE = 2'b11
    } mem_size_e;

    typedef struct packed {
        unit_e     unit;
        alu_op_e   alu_op;
        logic      word_op;    // compute on 32 bits, sign-extend
        br_cond_e  br_cond;
        mem_size_e mem_size;
        reg_addr_t rd;         // zero unless the class writes a register
    } exec_ctrl_t;

    typedef struct packed {
        logic eq;
        logic lt;     // signed
        logic ltu;
    } cmp_flags_t;

    typedef struct packed {
        logic      wen;
        reg_addr_t addr;
        xword_t    data;
    } wb_req_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        xword_t     raddr;
        xword_t     waddr;
        xword_t     wdata;
        logic [7:0] wmask;
    } mem_req_t;

    typedef struct packed {
        logic   en;
        xword_t addr;
    } jump_req_t;

endpackage

`default_nettype wire

// ==== design/ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  wire            clk,
    input  wire            rst_i,

    // operands prepared by the decode stage
    input  wire inst_t     inst_i,
    input  wire xword_t    op1_i,
    input  wire xword_t    op2_i,
    input  wire reg_addr_t rd_addr_i,
    input  wire xword_t    base_addr_i,
    input  wire xword_t    offset_addr_i,

    // registered requests to the next stage
    output wb_req_t        wb_o,
    output mem_req_t       mem_o,
    output jump_req_t      jump_o
);

    exec_ctrl_t ctrl;
    xword_t     alu_result;
    xword_t     addr_sum;
    cmp_flags_t cmp;

    wb_req_t    wb_d;
    mem_req_t   mem_d;
    jump_req_t  jump_d;

    ex_decode u_decode (
        .inst_i    (inst_i),
        .rd_addr_i (rd_addr_i),
        .ctrl_o    (ctrl)
    );

    ex_alu u_alu (
        .ctrl_i        (ctrl),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .base_addr_i   (base_addr_i),
        .offset_addr_i (offset_addr_i),
        .result_o      (alu_result),
        .addr_o        (addr_sum),
        .cmp_o         (cmp)
    );

    ex_branch u_branch (
        .ctrl_i (ctrl),
        .cmp_i  (cmp),
        .addr_i (addr_sum),
        .jump_o (jump_d)
    );

    ex_mem_req u_mem_req (
        .ctrl_i   (ctrl),
        .op2_i    (op2_i),
        .result_i (alu_result),
        .addr_i   (addr_sum),
        .wb_o     (wb_d),
        .mem_o    (mem_d)
    );

    // one pipeline boundary, loads every cycle since nothing stalls
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_o   <= '0;
            mem_o  <= '0;
            jump_o <= '0;
        end else begin
            wb_o   <= wb_d;
            mem_o  <= mem_d;
            jump_o <= jump_d;
        end
    end

endmodule

`default_nettype wire

// ==== tests/ex_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_checker
    import ex_pkg::*;
(
    input  wire            clk,
    input  wire            rst_i,
    input  wire inst_t     inst_i,
    input  wire xword_t    op1_i,
    input  wire xword_t    op2_i,
    input  wire reg_addr_t rd_addr_i,
    input  wire xword_t    base_addr_i,
    input  wire xword_t    offset_addr_i,
    input  wire wb_req_t   wb_i,
    input  wire mem_req_t  mem_i,
    input  wire jump_req_t jump_i,
    input  wire            done_i,
    output int             err_count_o
);

    typedef struct packed {
        wb_req_t   wb;
        mem_req_t  mem;
        jump_req_t jump;
    } expect_t;

    expect_t pending[$];   // one entry per sampled edge

    int wb_errs    = 0;
    int mem_errs   = 0;
    int jump_errs  = 0;
    int checks     = 0;

    assign err_count_o = wb_errs + mem_errs + jump_errs;

    function automatic wb_req_t wb_write(input reg_addr_t rd, input xword_t data);
        return {1'b1, rd, data};
    endfunction

    // alt selects SUB or SRA
    function automatic xword_t calc_xlen(input logic [2:0] f3, input logic alt,
                                         input xword_t a, input xword_t b);
        case (f3)
            3'd0: begin
                if (alt) return a - b;
                return a + b;
            end
            3'd1: return a << b[5:0];
            3'd2: return {63'd0, $signed(a) < $signed(b)};
            3'd3: return {63'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[5:0];
                return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic xword_t calc_word(input logic [2:0] f3, input logic alt,
                                         input xword_t a, input xword_t b);
        logic [31:0] w;
        case (f3)
            3'd1: w = a[31:0] << b[4:0];
            3'd5: begin
                if (alt) w = $signed(a[31:0]) >>> b[4:0];
                else     w = a[31:0] >> b[4:0];
            end
            default: begin
                if (alt) w = a[31:0] - b[31:0];
                else     w = a[31:0] + b[31:0];
            end
        endcase
        return {{32{w[31]}}, w};
    endfunction

    function automatic expect_t reference(input inst_t inst, input xword_t a, input xword_t b,
                                          input reg_addr_t rd, input xword_t sum);
        expect_t    e;
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        logic       taken;
        int         nbytes;
        e     = '0;
        opc   = inst[6:0];
        f3    = inst[14:12];
        f7    = inst[31:25];
        taken = 1'b0;
        case (opc)
            7'b0110011: begin   // OP
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
                    e.wb = wb_write(rd, calc_xlen(f3, f7[5], a, b));
            end
            7'b0010011: begin   // OP-IMM shifts keep shamt[5] in inst[25]
                if ((f3 != 3'd1 && f3 != 3'd5) || inst[31:26] == 6'd0 ||
                    (f3 == 3'd5 && inst[31:26] == 6'b010000))
                    e.wb = wb_write(rd, calc_xlen(f3, (f3 == 3'd5) && inst[30], a, b));
            end
            7'b0111011: begin   // OP-32
                if ((f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5) &&
                    (f7 == 7'h00 || (f7 == 7'h20 && f3 != 3'd1)))
                    e.wb = wb_write(rd, calc_word(f3, f7[5], a, b));
            end
            7'b0011011: begin   // OP-IMM-32
                if (f3 == 3'd0)
                    e.wb = wb_write(rd, calc_word(f3, 1'b0, a, b));
                else if ((f3 == 3'd1 && f7 == 7'h00) ||
                         (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20)))
                    e.wb = wb_write(rd, calc_word(f3, f7[5], a, b));
            end
            7'b0110111: e.wb = wb_write(rd, b);       // LUI
            7'b0010111: e.wb = wb_write(rd, a + b);   // AUIPC
            7'b1101111, 7'b1100111: begin
                if (opc == 7'b1101111 || f3 == 3'd0) begin
                    e.wb   = wb_write(rd, a + b);   // link value
                    e.jump = {1'b1, sum};
                end
            end
            7'b1100011: begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    3'd7:    taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) e.jump = {1'b1, sum};
            end
            7'b0000011: begin
                if (f3 != 3'd7) begin
                    e.wb        = wb_write(rd, '0);
                    e.mem.ren   = 1'b1;
                    e.mem.raddr = sum;
                end
            end
            7'b0100011: begin
                if (!f3[2]) begin
                    nbytes      = 1 << f3[1:0];
                    e.mem.wen   = 1'b1;
                    e.mem.waddr = sum;
                    e.mem.wmask = 8'((1 << nbytes) - 1);
                    if (nbytes == 8) e.mem.wdata = b;
                    else e.mem.wdata = b & ((64'd1 << (8 * nbytes)) - 64'd1);
                end
            end
            default: e = '0;   // CSR, M ext and unknown words
        endcase
        return e;
    endfunction

    always @(posedge clk) begin
        expect_t exp_v;
        if (pending.size() > 0) begin
            exp_v  = pending.pop_front();
            checks = checks + 1;
            if (wb_i !== exp_v.wb) begin
                wb_errs = wb_errs + 1;
                $display("[FAIL] t=%0d ns wb_o expected %h got %h", $time, exp_v.wb, wb_i);
            end
            if (mem_i !== exp_v.mem) begin
                mem_errs = mem_errs + 1;
                $display("[FAIL] t=%0d ns mem_o expected %h got %h", $time, exp_v.mem, mem_i);
            end
            if (jump_i !== exp_v.jump) begin
                jump_errs = jump_errs + 1;
                $display("[FAIL] t=%0d ns jump_o expected %h got %h", $time, exp_v.jump, jump_i);
            end
        end
        if (rst_i)
            pending.push_back('0);   // registers clear on this edge
        else
            pending.push_back(reference(inst_i, op1_i, op2_i, rd_addr_i,
                                        base_addr_i + offset_addr_i));
    end

    always @(posedge done_i) begin
        $display("checks %0d, errors %0d: wb_o %0d, mem_o %0d, jump_o %0d",
                 checks, wb_errs + mem_errs + jump_errs,
                 wb_errs, mem_errs, jump_errs);
    end

endmodule

`default_nettype wire

// ==== tests/tb_ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int          N_TESTS        = 400;
    localparam int          RESET_CYCLES   = 5;
    localparam int          TIMEOUT_CYCLES = N_TESTS + RESET_CYCLES + 20;
    localparam logic [31:0] SEED           = 32'hae1eba5e;

    logic      clk = 1'b0;
    logic      rst;
    inst_t     inst;
    xword_t    op1;
    xword_t    op2;
    reg_addr_t rd_addr;
    xword_t    base_addr;
    xword_t    offset_addr;
    wb_req_t   wb;
    mem_req_t  mem;
    jump_req_t jump;

    logic        done;
    int          err_count;
    int          cycles = 0;
    logic [31:0] lfsr   = SEED;

    always #10 clk = ~clk;   // 20 ns period

    ex_stage DUT (
        .clk           (clk),
        .rst_i         (rst),
        .inst_i        (inst),
        .op1_i         (op1),
        .op2_i         (op2),
        .rd_addr_i     (rd_addr),
        .base_addr_i   (base_addr),
        .offset_addr_i (offset_addr),
        .wb_o          (wb),
        .mem_o         (mem),
        .jump_o        (jump)
    );

    ex_checker u_checker (
        .clk           (clk),
        .rst_i         (rst),
        .inst_i        (inst),
        .op1_i         (op1),
        .op2_i         (op2),
        .rd_addr_i     (rd_addr),
        .base_addr_i   (base_addr),
        .offset_addr_i (offset_addr),
        .wb_i          (wb),
        .mem_i         (mem),
        .jump_i        (jump),
        .done_i        (done),
        .err_count_o   (err_count)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    function automatic logic [6:0] pick_opcode(input logic [3:0] k);
        case (k)
            4'd0, 4'd11, 4'd14: return 7'b0110011;   // OP with kind 11 forced to M ext
            4'd1, 4'd15:        return 7'b0010011;   // OP-IMM
            4'd2, 4'd12:        return 7'b0111011;   // OP-32 with kind 12 forced to M ext
            4'd3:               return 7'b0011011;   // OP-IMM-32
            4'd4:               return 7'b1100011;   // branches
            4'd5:               return 7'b0000011;   // loads
            4'd6:               return 7'b0100011;   // stores
            4'd7:               return 7'b1101111;
            4'd8:               return 7'b1100111;
            4'd9:               return 7'b0110111;
            4'd10:              return 7'b0010111;
            default:            return 7'b1110011;   // SYSTEM for CSR access
        endcase
    endfunction

    task automatic drive_random();
        logic [63:0] r;
        logic [3:0]  kind;
        logic [31:0] word;
        take_bits(32, r);
        word = r[31:0];
        take_bits(4, r);
        kind       = r[3:0];
        word[6:0]  = pick_opcode(kind);
        take_bits(2, r);
        if (kind == 4'd11 || kind == 4'd12) begin
            word[31:25] = 7'b0000001;   // MUL/DIV family
        end else if (r[1:0] != 2'd0) begin
            // push func7 towards legal encodings for three quarters of the words
            word[31:26] = r[1] ? 6'b010000 : 6'b000000;
            if (word[6:0] == 7'b0110011 || word[6:0] == 7'b0111011) word[25] = 1'b0;
        end
        inst = word;
        take_bits(64, r);
        op1 = r;
        take_bits(64, r);
        op2 = r;
        take_bits(2, r);
        if (r[1:0] == 2'd0) op2 = op1;   // equal operands for EQ/GE
        take_bits(5, r);
        rd_addr = r[4:0];
        take_bits(64, r);
        base_addr = r;
        take_bits(64, r);
        offset_addr = r;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the stimulus never finished", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        rst         = 1'b1;
        inst        = '0;
        op1         = '0;
        op2         = '0;
        rd_addr     = '0;
        base_addr   = '0;
        offset_addr = '0;
        done        = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < N_TESTS; i++) begin
            drive_random();
            @(negedge clk);
        end
        inst = '0;   // idle word while the last result drains
        repeat (2) @(negedge clk);
        done = 1'b1;
        #1;
        if (err_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
